// ==== Bender.yml ====
package:
  name: cnn_accel

sources:
  - files:
      - source/cnn_pkg.sv
      - source/weight_loader.sv
      - source/patch_fetch.sv
      - source/conv_pool.sv
      - source/output_packer.sv
      - source/cnn_top.sv
  - target: any(simulation, test)
    files:
      - verification/cnn_sva.sv
      - verification/cnn_tb.sv

// ==== all.f ====
source/cnn_pkg.sv
source/weight_loader.sv
source/patch_fetch.sv
source/conv_pool.sv
source/output_packer.sv
source/cnn_top.sv
verification/cnn_sva.sv
verification/cnn_tb.sv

// ==== source/cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

  // --------------------
  // data types

  typedef logic [15:0] word_t;          // one sram word
  typedef logic signed [7:0] pixel_t;   // input pixel or kernel tap
  typedef logic signed [19:0] acc_t;    // 3x3 sum, 9 * 127 * 128 fits easily
  typedef logic [7:0] pooled_t;         // after relu and max, 0..127

  // 4x4 patch, element index is row*4 + col
  typedef pixel_t [15:0] patch_t;

  // 3x3 kernel, element index is row*3 + col
  typedef pixel_t [8:0] taps_t;

  typedef logic [6:0] dim_t;            // matrix size N, 4..64

  // --------------------
  // constants

  localparam int ADDR_W = 12;           // default sram address width
  localparam int RELU_MAX = 127;        // clamp ceiling
  localparam word_t END_MARK = 16'hFFFF;  // terminates the matrix list
  localparam int TAP_WORDS = 5;         // weight words holding nine taps
  localparam int PATCH_READS = 8;       // 4 rows x 2 words

endpackage

`default_nettype wire

// ==== source/cnn_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cnn_top #(
  parameter int addr_w = cnn_pkg::ADDR_W
) (
  input  wire logic            clk,
  input  wire logic            reset_b,

  // --------------------
  // control
  input  wire logic            dut_run,
  output logic                 dut_busy,

  // --------------------
  // input sram, read only
  output logic [addr_w-1:0]    input_sram_read_address,
  input  wire cnn_pkg::word_t  input_sram_read_data,

  // --------------------
  // weights sram, read only
  output logic [addr_w-1:0]    weights_sram_read_address,
  input  wire cnn_pkg::word_t  weights_sram_read_data,

  // --------------------
  // output sram, write only
  output logic                 output_sram_write_enable,
  output logic [addr_w-1:0]    output_sram_write_address,
  output cnn_pkg::word_t       output_sram_write_data
);

  import cnn_pkg::*;

  taps_t   taps;
  logic    taps_valid;
  logic    load_start;   // one pulse per run
  patch_t  patch;
  logic    patch_valid;
  logic    patch_last;
  pooled_t pooled;
  logic    pool_valid;
  logic    pool_last;

  weight_loader #(
    .addr_w (addr_w)
  ) u_weight_loader (
    .clk                       (clk),
    .reset_b                   (reset_b),
    .start                     (load_start),
    .weights_sram_read_data    (weights_sram_read_data),
    .weights_sram_read_address (weights_sram_read_address),
    .taps                      (taps),
    .taps_valid                (taps_valid)
  );

  patch_fetch #(
    .addr_w (addr_w)
  ) u_patch_fetch (
    .clk                     (clk),
    .reset_b                 (reset_b),
    .dut_run                 (dut_run),
    .taps_valid              (taps_valid),
    .input_sram_read_data    (input_sram_read_data),
    .input_sram_read_address (input_sram_read_address),
    .load_start              (load_start),
    .patch                   (patch),
    .patch_valid             (patch_valid),
    .patch_last              (patch_last),
    .dut_busy                (dut_busy)
  );

  conv_pool u_conv_pool (
    .clk         (clk),
    .reset_b     (reset_b),
    .taps        (taps),
    .patch       (patch),
    .patch_valid (patch_valid),
    .patch_last  (patch_last),
    .pooled      (pooled),
    .pool_valid  (pool_valid),
    .pool_last   (pool_last)
  );

  output_packer #(
    .addr_w (addr_w)
  ) u_output_packer (
    .clk                       (clk),
    .reset_b                   (reset_b),
    .start                     (load_start),
    .pooled                    (pooled),
    .pool_valid                (pool_valid),
    .pool_last                 (pool_last),
    .output_sram_write_enable  (output_sram_write_enable),
    .output_sram_write_address (output_sram_write_address),
    .output_sram_write_data    (output_sram_write_data)
  );

endmodule

`default_nettype wire

// ==== source/conv_pool.sv ====
`timescale 1ns/1ns
`default_nettype none

module conv_pool (
  input  wire logic             clk,
  input  wire logic             reset_b,
  input  wire cnn_pkg::taps_t   taps,
  input  wire cnn_pkg::patch_t  patch,
  input  wire logic             patch_valid,
  input  wire logic             patch_last,
  output cnn_pkg::pooled_t      pooled,
  output logic                  pool_valid,
  output logic                  pool_last
);

  import cnn_pkg::*;

  acc_t    sum_q [4];  // conv results at (0,0) (0,1) (1,0) (1,1)
  logic    valid_q;
  logic    last_q;
  pooled_t pool_max;

  // 3x3 window with its top-left corner at (r0, c0) of the patch
  function automatic acc_t conv3(input patch_t p, input taps_t k, input int r0, input int c0);
    acc_t acc;
    acc = '0;
    for (int i = 0; i < 3; i++)
    begin
      for (int j = 0; j < 3; j++)
        acc = acc + acc_t'(signed'(p[(r0 + i) * 4 + c0 + j])) * acc_t'(signed'(k[i * 3 + j]));
    end
    return acc;
  endfunction

  function automatic pooled_t relu(input acc_t a);
    if (a < 0)
      return '0;
    else if (a > RELU_MAX)
      return pooled_t'(RELU_MAX);
    else
      return pooled_t'(a);
  endfunction

  // --------------------
  // stage 1, four convolutions
  always_ff @(posedge clk)
  begin
    if (patch_valid)
    begin
      sum_q[0] <= conv3(patch, taps, 0, 0);
      sum_q[1] <= conv3(patch, taps, 0, 1);
      sum_q[2] <= conv3(patch, taps, 1, 0);
      sum_q[3] <= conv3(patch, taps, 1, 1);
    end
  end

  // --------------------
  // stage 2, clamp and 2x2 max
  always_comb
  begin
    pool_max = '0;
    for (int i = 0; i < 4; i++)
    begin
      if (relu(sum_q[i]) > pool_max)
        pool_max = relu(sum_q[i]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (valid_q)
      pooled <= pool_max;
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      pool_valid <= 1'b0;
      pool_last  <= 1'b0;
    end
    else
    begin
      valid_q    <= patch_valid;
      last_q     <= patch_valid && patch_last;
      pool_valid <= valid_q;
      pool_last  <= last_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/output_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module output_packer #(
  parameter int addr_w = cnn_pkg::ADDR_W
) (
  input  wire logic              clk,
  input  wire logic              reset_b,
  input  wire logic              start,
  input  wire cnn_pkg::pooled_t  pooled,
  input  wire logic              pool_valid,
  input  wire logic              pool_last,
  output logic                   output_sram_write_enable,
  output logic [addr_w-1:0]      output_sram_write_address,
  output cnn_pkg::word_t         output_sram_write_data
);

  import cnn_pkg::*;

  pooled_t lo_byte;    // first value of a pair
  logic    half_full;  // lo_byte holds a value

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      half_full                 <= 1'b0;
      output_sram_write_enable  <= 1'b0;
      output_sram_write_address <= '0;
    end
    else
    begin
      // pair complete or matrix ends
      output_sram_write_enable <= pool_valid && (half_full || pool_last);
      if (start)
      begin
        half_full                 <= 1'b0;
        output_sram_write_address <= '0;
      end
      else
      begin
        if (output_sram_write_enable)
          output_sram_write_address <= output_sram_write_address + addr_w'(1);
        if (pool_valid)
          half_full <= !half_full && !pool_last;  // cleared at matrix end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pool_valid)
    begin
      if (half_full)
        output_sram_write_data <= {pooled, lo_byte};
      else if (pool_last)
        output_sram_write_data <= {8'h00, pooled};  // odd value, zero high byte
      else
        lo_byte <= pooled;
    end
  end

endmodule

`default_nettype wire

// ==== source/patch_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module patch_fetch #(
  parameter int addr_w = cnn_pkg::ADDR_W
) (
  input  wire logic            clk,
  input  wire logic            reset_b,
  input  wire logic            dut_run,
  input  wire logic            taps_valid,
  input  wire cnn_pkg::word_t  input_sram_read_data,
  output logic [addr_w-1:0]    input_sram_read_address,
  output logic                 load_start,
  output cnn_pkg::patch_t      patch,
  output logic                 patch_valid,
  output logic                 patch_last,
  output logic                 dut_busy
);

  import cnn_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_wait_taps,
    st_read_hdr,
    st_fetch,
    st_drain
  } state_t;

  state_t            state;
  logic              hdr_wait;    // header data arrives this cycle
  logic [addr_w-1:0] hdr_addr;    // address of current header word
  dim_t              n;
  dim_t              half;        // words per matrix row
  dim_t              pool_n;      // pooled outputs per row and column
  dim_t              row;         // pooled row
  dim_t              col;         // pooled column
  logic [2:0]        rd_idx;      // read number within the patch
  logic              last_pos;
  logic [addr_w-1:0] patch_base;
  logic [1:0]        drain_cnt;
  logic              rd_valid_q;  // patch word on the read data bus
  logic [2:0]        rd_idx_q;
  logic              rd_last_q;

  assign half     = n >> 1;
  assign pool_n   = (n - dim_t'(2)) >> 1;
  assign last_pos = (row == pool_n - dim_t'(1)) && (col == pool_n - dim_t'(1));

  // top-left word of the patch: header + 1 + 2*row*(N/2) + col
  assign patch_base = hdr_addr + addr_w'(1) + addr_w'(2) * addr_w'(row) * addr_w'(half)
                      + addr_w'(col);

  // two words per patch row, rows N/2 words apart
  always_comb
  begin
    if (state == st_fetch)
      input_sram_read_address = patch_base + addr_w'(rd_idx[2:1]) * addr_w'(half)
                                + addr_w'(rd_idx[0]);
    else
      input_sram_read_address = hdr_addr;
  end

  assign load_start = (state == st_idle) && dut_run;
  assign dut_busy   = (state != st_idle);

  // --------------------
  // run control
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state     <= st_idle;
      hdr_wait  <= 1'b0;
      hdr_addr  <= '0;
      n         <= '0;
      row       <= '0;
      col       <= '0;
      rd_idx    <= '0;
      drain_cnt <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (dut_run)
          begin
            state    <= st_wait_taps;
            hdr_addr <= '0;
          end
        st_wait_taps:
          if (taps_valid)
          begin
            state    <= st_read_hdr;
            hdr_wait <= 1'b0;
          end
        st_read_hdr:
        begin
          hdr_wait <= ~hdr_wait;
          if (hdr_wait)
          begin
            if (input_sram_read_data == END_MARK)
            begin
              state     <= st_drain;
              drain_cnt <= '0;
            end
            else
            begin
              state  <= st_fetch;
              n      <= input_sram_read_data[6:0];  // N from low byte
              row    <= '0;
              col    <= '0;
              rd_idx <= '0;
            end
          end
        end
        st_fetch:
        begin
          rd_idx <= rd_idx + 3'd1;  // wraps to 0 after the eighth read
          if (rd_idx == 3'(PATCH_READS - 1))
          begin
            if (last_pos)
            begin
              state    <= st_read_hdr;
              hdr_addr <= hdr_addr + addr_w'(1) + addr_w'(n) * addr_w'(half);
            end
            else if (col == pool_n - dim_t'(1))
            begin
              col <= '0;
              row <= row + dim_t'(1);
            end
            else
              col <= col + dim_t'(1);
          end
        end
        st_drain:
        begin
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == 2'd3)  // conv_pool and packer empty by now
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // --------------------
  // patch assembly
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      rd_valid_q  <= 1'b0;
      rd_idx_q    <= '0;
      rd_last_q   <= 1'b0;
      patch_valid <= 1'b0;
      patch_last  <= 1'b0;
    end
    else
    begin
      rd_valid_q  <= (state == st_fetch);
      rd_idx_q    <= rd_idx;
      rd_last_q   <= last_pos;
      patch_valid <= rd_valid_q && (rd_idx_q == 3'(PATCH_READS - 1));
      patch_last  <= rd_valid_q && rd_last_q && (rd_idx_q == 3'(PATCH_READS - 1));
    end
  end

  // new pixels enter at the top, first word ends up at index 0 and 1
  always_ff @(posedge clk)
  begin
    if (rd_valid_q)
      patch <= {input_sram_read_data[7:0], input_sram_read_data[15:8], patch[15:2]};
  end

endmodule

`default_nettype wire

// ==== source/weight_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

module weight_loader #(
  parameter int addr_w = cnn_pkg::ADDR_W
) (
  input  wire logic            clk,
  input  wire logic            reset_b,
  input  wire logic            start,
  input  wire cnn_pkg::word_t  weights_sram_read_data,
  output logic [addr_w-1:0]    weights_sram_read_address,
  output cnn_pkg::taps_t       taps,
  output logic                 taps_valid
);

  import cnn_pkg::*;

  logic       loading;  // words still arriving
  logic [2:0] step;     // index of the word on the read data bus

  // word 0 goes out while idle, the counter supplies words 1..4
  always_comb
  begin
    if (loading && step < 3'(TAP_WORDS - 1))
      weights_sram_read_address = addr_w'(step + 3'd1);
    else
      weights_sram_read_address = '0;
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      loading    <= 1'b0;
      step       <= '0;
      taps_valid <= 1'b0;
    end
    else if (start)
    begin
      loading    <= 1'b1;
      step       <= '0;
      taps_valid <= 1'b0;        // old kernel no longer valid
    end
    else if (loading)
    begin
      if (step == 3'(TAP_WORDS - 1))
      begin
        loading    <= 1'b0;
        taps_valid <= 1'b1;
      end
      step <= step + 3'd1;
    end
  end

  // word k carries taps 2k (high byte) and 2k+1 (low byte)
  always_ff @(posedge clk)
  begin
    if (loading)
    begin
      taps[2*step] <= weights_sram_read_data[15:8];
      if (step != 3'(TAP_WORDS - 1))
        taps[2*step+1] <= weights_sram_read_data[7:0];  // unused in last word
    end
  end

endmodule

`default_nettype wire

// ==== verification/cnn_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module cnn_sva #(
  parameter int addr_w = cnn_pkg::ADDR_W
) (
  input wire logic              clk,
  input wire logic              reset_b,
  input wire logic              dut_run,
  input wire logic              dut_busy,
  input wire logic              output_sram_write_enable,
  input wire logic [addr_w-1:0] output_sram_write_address
);

  logic [addr_w-1:0] last_addr;       // address of the previous write
  logic              wrote;           // a write happened in this run
  int                fail_count = 0;  // number of failed assertions

  always @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
      wrote <= 1'b0;
    else if (dut_run && !dut_busy)
      wrote <= 1'b0;             // new run
    else if (output_sram_write_enable)
    begin
      wrote     <= 1'b1;
      last_addr <= output_sram_write_address;
    end
  end

  write_inside_run: assert property (@(posedge clk) disable iff (!reset_b)
    output_sram_write_enable |-> dut_busy)
  else
  begin
    fail_count++;
    $error("output write while dut_busy is low");
  end

  idle_after_reset: assert property (@(posedge clk)
    $rose(reset_b) |-> !dut_busy && !output_sram_write_enable)
  else
  begin
    fail_count++;
    $error("dut_busy or write enable high after reset");
  end

  address_steps_by_one: assert property (@(posedge clk) disable iff (!reset_b)
    output_sram_write_enable && wrote |-> output_sram_write_address == last_addr + 1'b1)
  else
  begin
    fail_count++;
    $error("output write address did not advance by one");
  end

endmodule

bind cnn_top cnn_sva #(
  .addr_w (addr_w)
) u_cnn_sva (
  .clk                       (clk),
  .reset_b                   (reset_b),
  .dut_run                   (dut_run),
  .dut_busy                  (dut_busy),
  .output_sram_write_enable  (output_sram_write_enable),
  .output_sram_write_address (output_sram_write_address)
);

`default_nettype wire

// ==== verification/cnn_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cnn_tb;

  import cnn_pkg::*;

  localparam int addr_w = ADDR_W;
  localparam int mem_words = 1 << addr_w;

  logic              clk;
  logic              reset_b;
  logic              dut_run;
  logic              dut_busy;
  logic [addr_w-1:0] input_sram_read_address;
  word_t             input_sram_read_data;
  logic [addr_w-1:0] weights_sram_read_address;
  word_t             weights_sram_read_data;
  logic              output_sram_write_enable;
  logic [addr_w-1:0] output_sram_write_address;
  word_t             output_sram_write_data;

  word_t             input_mem [mem_words];
  word_t             weights_mem [mem_words];
  int                kernel [9];        // taps of the current run
  word_t             expected [$];
  word_t             written_data [$];
  logic [addr_w-1:0] written_addr [$];
  int                list_ptr;          // next free input word
  int                run_pooled;        // pooled outputs in this run
  int                cycle_count;
  int                cycle_limit;

  cnn_top #(
    .addr_w (addr_w)
  ) DUT (
    .clk                       (clk),
    .reset_b                   (reset_b),
    .dut_run                   (dut_run),
    .dut_busy                  (dut_busy),
    .input_sram_read_address   (input_sram_read_address),
    .input_sram_read_data      (input_sram_read_data),
    .weights_sram_read_address (weights_sram_read_address),
    .weights_sram_read_data    (weights_sram_read_data),
    .output_sram_write_enable  (output_sram_write_enable),
    .output_sram_write_address (output_sram_write_address),
    .output_sram_write_data    (output_sram_write_data)
  );

  always #10 clk = ~clk;

  // --------------------
  // sram models and write capture
  always @(posedge clk)
  begin
    input_sram_read_data   <= input_mem[input_sram_read_address];    // one-cycle read
    weights_sram_read_data <= weights_mem[weights_sram_read_address];
  end

  always @(negedge clk)
  begin
    if (reset_b && output_sram_write_enable === 1'b1)
    begin
      written_addr.push_back(output_sram_write_address);
      written_data.push_back(output_sram_write_data);
    end
  end

  always @(posedge clk)
  begin
    if (DUT.u_cnn_sva.fail_count != 0)
      stop_on_failure("an assertion in cnn_sva failed");
    else if (reset_b)
    begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
        stop_on_failure($sformatf("timeout, DUT still busy after %0d cycles", cycle_limit));
    end
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_failure("output data differs from the model");
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_w-1:0] got,
                            input logic [addr_w-1:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_failure("output address out of sequence");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_failure("wrong number of output writes");
    end
  endtask

  // --------------------
  // stimulus
  task automatic set_taps(input bit saturate);
    pixel_t p;
    for (int t = 0; t < 9; t++)
    begin
      p = saturate ? pixel_t'(127) : pixel_t'($urandom);
      kernel[t] = p;
    end
    for (int k = 0; k < 4; k++)
      weights_mem[k] = {kernel[2*k][7:0], kernel[2*k+1][7:0]};
    weights_mem[4] = {kernel[8][7:0], 8'($urandom)};  // low byte unused
  endtask

  task automatic start_list();
    for (int a = 0; a < mem_words; a++)
      input_mem[a] = word_t'((a * 40503) ^ (a << 3) ^ 16'h5A5A);
    list_ptr   = 0;
    run_pooled = 0;
  endtask

  task automatic add_matrix(input int n, input bit random_fill, input pixel_t value);
    pixel_t hi;
    pixel_t lo;
    input_mem[list_ptr] = word_t'(n);
    for (int w = 0; w < n * n / 2; w++)
    begin
      hi = random_fill ? pixel_t'($urandom) : value;
      lo = random_fill ? pixel_t'($urandom) : value;
      input_mem[list_ptr + 1 + w] = {hi, lo};  // even column high
    end
    list_ptr   = list_ptr + 1 + n * n / 2;
    run_pooled = run_pooled + ((n - 2) / 2) * ((n - 2) / 2);
  endtask

  // --------------------
  // reference model
  function automatic int pixel_at(input int hdr, input int n, input int r, input int c);
    word_t  w;
    pixel_t p;
    w = input_mem[hdr + 1 + r * (n / 2) + c / 2];
    p = (c % 2 == 0) ? w[15:8] : w[7:0];
    return p;
  endfunction

  task automatic build_expected();
    int      hdr;
    int      n;
    int      pn;
    int      sum;
    pooled_t best;
    pooled_t val;
    pooled_t lo;
    bit      have_lo;
    expected.delete();
    hdr = 0;
    while (input_mem[hdr] != END_MARK)
    begin
      n       = input_mem[hdr][7:0];
      pn      = (n - 2) / 2;
      have_lo = 1'b0;
      for (int r = 0; r < pn; r++)
      begin
        for (int c = 0; c < pn; c++)
        begin
          best = '0;
          for (int q = 0; q < 4; q++)
          begin
            sum = 0;
            for (int i = 0; i < 3; i++)
            begin
              for (int j = 0; j < 3; j++)
                sum += pixel_at(hdr, n, 2*r + q/2 + i, 2*c + q%2 + j) * kernel[i*3 + j];
            end
            val = (sum < 0) ? 8'd0 : (sum > RELU_MAX) ? 8'd127 : pooled_t'(sum);
            if (val > best)
              best = val;
          end
          if (have_lo)
            expected.push_back({best, lo});
          else
            lo = best;
          have_lo = !have_lo;
        end
      end
      if (have_lo)
        expected.push_back({8'h00, lo});  // zero high byte after an odd count
      hdr = hdr + 1 + n * n / 2;
    end
  endtask

  task automatic run_and_check(input string label);
    input_mem[list_ptr] = END_MARK;
    cycle_limit = cycle_limit + 12 * run_pooled + 200;
    build_expected();
    written_addr.delete();
    written_data.delete();
    dut_run = 1'b1;
    @(negedge clk);
    dut_run = 1'b0;
    if (dut_busy !== 1'b1)
      stop_on_failure("dut_busy did not rise after dut_run");
    while (dut_busy === 1'b1)
      @(negedge clk);
    check_count("output write count", written_data.size(), expected.size());
    for (int i = 0; i < expected.size(); i++)
    begin
      check_addr($sformatf("output_sram_write_address[%0d]", i), written_addr[i], addr_w'(i));
      check_word($sformatf("output_sram_write_data[%0d]", i), written_data[i], expected[i]);
    end
    $display("%s: %0d output words", label, expected.size());
    repeat (2) @(negedge clk);
  endtask

  initial
  begin
    void'($urandom(47002));
    clk                    = 1'b0;
    reset_b                = 1'b0;
    dut_run                = 1'b0;
    input_sram_read_data   = '0;
    weights_sram_read_data = '0;
    cycle_count            = 0;
    cycle_limit            = 0;
    for (int a = 0; a < mem_words; a++)
      weights_mem[a] = word_t'((a * 27111) ^ 16'hC3A5);
    start_list();
    repeat (4) @(negedge clk);
    reset_b = 1'b1;

    set_taps(1'b0);  // one 4x4 matrix
    start_list();
    add_matrix(4, 1'b1, 0);
    run_and_check("single matrix");

    set_taps(1'b0);  // odd and even pooled counts
    start_list();
    add_matrix(8, 1'b1, 0);
    add_matrix(10, 1'b1, 0);
    for (int m = 0; m < 3; m++)
      add_matrix(4 + 2 * ($urandom % 7), 1'b1, 0);
    run_and_check("matrix list");

    set_taps(1'b1);  // clamp at both ends
    start_list();
    add_matrix(6, 1'b0, 127);
    add_matrix(4, 1'b0, -128);
    add_matrix(6, 1'b0, -128);
    add_matrix(4, 1'b0, 127);
    run_and_check("saturation");

    set_taps(1'b0);
    start_list();
    for (int m = 0; m < 4; m++)
      add_matrix(4 + 2 * ($urandom % 7), 1'b1, 0);
    run_and_check("second list");

    set_taps(1'b0);
    start_list();
    run_and_check("empty list");

    if (DUT.u_cnn_sva.fail_count != 0)
      stop_on_failure("an assertion in cnn_sva failed");
    else
    begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
